/* Makefile */
VERILATOR ?= verilator
TOP       ?= controlUnitTb
FLIST     ?= controlUnit.f
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timescale 1ns/100ps

BIN  := $(BUILD)/V$(TOP)
SRCS := $(wildcard logic/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(BUILD)

/* controlUnit.f */
+incdir+dv
logic/controlPkg.sv
logic/instrDecoder.sv
logic/stepSequencer.sv
logic/controlWordTable.sv
logic/controlUnit.sv
dv/controlUnitTb.sv

/* dv/controlUnitTasks.svh */
`ifndef CONTROL_UNIT_TASKS_SVH
`define CONTROL_UNIT_TASKS_SVH

logic [15:0] lfsrState;

// Expected control word
logic                 expPcWrite;
logic                 expMemRead;
logic                 expIrWrite;
logic                 expRegWrite;
logic                 expLoadA;
logic                 expLoadB;
logic                 expAluOutWrite;
logic                 expMdrWrite;
logic                 expSelectByte;
logic                 expCpuReset;
controlPkg::aluOpT    expAluOp;
controlPkg::iorDT     expIorD;
controlPkg::regDstT   expRegDst;
controlPkg::aluSrcAT  expAluSrcA;
controlPkg::aluSrcBT  expAluSrcB;
controlPkg::memToRegT expMemToReg;
controlPkg::byteSrcT  expByteSrc;

// 16-bit Galois LFSR giving one bit per call
function automatic logic lfsrBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit) begin
        lfsrState = lfsrState ^ 16'hB400;
    end
    return outBit;
endfunction

task automatic drawPair(output logic [5:0] op, output logic [5:0] fn);
    for (int i = 0; i < 6; i++) begin
        op[i] = lfsrBit();
    end
    for (int i = 0; i < 6; i++) begin
        fn[i] = lfsrBit();
    end
endtask

// Builds the word for one step with unnamed signals at zero
task automatic setExpected(input controlPkg::seqT s, input int st);
    {expPcWrite, expMemRead, expIrWrite, expRegWrite, expLoadA, expLoadB} = '0;
    {expAluOutWrite, expMdrWrite, expSelectByte, expCpuReset} = '0;
    {expAluOp, expIorD, expRegDst, expAluSrcA, expAluSrcB, expMemToReg, expByteSrc} = '0;
    case (s)
        controlPkg::seqReset: expCpuReset = 1'b1;
        controlPkg::seqFetch: begin
            expMemRead = 1'b1;
            expAluOp   = controlPkg::aluAdd;
            expAluSrcA = controlPkg::srcAPc;
            if (st < 4) begin
                expPcWrite = 1'b1;
                expIrWrite = 1'b1;
                expIorD    = controlPkg::iorDPc;
                expAluSrcB = controlPkg::srcBFour;
            end else begin
                expLoadA   = 1'b1;
                expLoadB   = 1'b1;
                expAluSrcB = controlPkg::srcBBranchOff;
            end
        end
        controlPkg::seqAdd, controlPkg::seqAddi: begin
            expRegWrite = 1'b1;
            expAluSrcA  = controlPkg::srcARegA;
            expAluSrcB  = controlPkg::srcBRegB;
            expRegDst   = controlPkg::regDstRd;
            if (st == 0) begin
                expAluOutWrite = 1'b1;
                if (s == controlPkg::seqAddi) begin
                    expRegDst  = controlPkg::regDstRt;
                    expAluSrcB = controlPkg::srcBImm;
                end
            end else begin
                expMemToReg = controlPkg::m2rAluOut;
                expByteSrc  = controlPkg::byteSrcReg;
                expLoadA    = (st == 2);
                expLoadB    = (st == 2);
            end
        end
        controlPkg::seqMfhi, controlPkg::seqMflo: begin
            expRegWrite = 1'b1;
            expByteSrc  = controlPkg::byteSrcReg;
            expMemToReg = (s == controlPkg::seqMfhi) ? controlPkg::m2rHi : controlPkg::m2rLo;
        end
        controlPkg::seqLb: begin
            expAluSrcA = controlPkg::srcARegA;
            expAluSrcB = controlPkg::srcBImm;
            if (st == 0) begin
                expAluOutWrite = 1'b1;
                expSelectByte  = 1'b1;
            end else if (st < 3) begin
                expMemRead    = 1'b1;
                expIorD       = controlPkg::iorDAluOut;
                expSelectByte = 1'b1;
            end else begin
                expRegWrite = 1'b1;
                expMdrWrite = 1'b1;
                expIorD     = controlPkg::iorDAluOut;
                expMemToReg = controlPkg::m2rMdr;
                expByteSrc  = controlPkg::byteSrcReg;
            end
        end
        default: ;
    endcase
endtask

task automatic checkField(input string label, input string name,
                          input logic [2:0] actual, input logic [2:0] expected);
    checkCount++;
    if (actual !== expected) begin
        errorCount++;
        $display("FAILED at %0t: %s, %s is %0d, expected %0d",
                 $time, label, name, actual, expected);
    end
endtask

task automatic compareWord(input string label);
    checkField(label, "pcWrite", 3'(pcWrite), 3'(expPcWrite));
    checkField(label, "memRead", 3'(memRead), 3'(expMemRead));
    checkField(label, "irWrite", 3'(irWrite), 3'(expIrWrite));
    checkField(label, "regWrite", 3'(regWrite), 3'(expRegWrite));
    checkField(label, "loadA", 3'(loadA), 3'(expLoadA));
    checkField(label, "loadB", 3'(loadB), 3'(expLoadB));
    checkField(label, "aluOutWrite", 3'(aluOutWrite), 3'(expAluOutWrite));
    checkField(label, "mdrWrite", 3'(mdrWrite), 3'(expMdrWrite));
    checkField(label, "selectByte", 3'(selectByte), 3'(expSelectByte));
    checkField(label, "cpuReset", 3'(cpuReset), 3'(expCpuReset));
    checkField(label, "aluOp", 3'(aluOp), 3'(expAluOp));
    checkField(label, "iorD", 3'(iorD), 3'(expIorD));
    checkField(label, "regDst", 3'(regDst), 3'(expRegDst));
    checkField(label, "aluSrcA", 3'(aluSrcA), 3'(expAluSrcA));
    checkField(label, "aluSrcB", 3'(aluSrcB), 3'(expAluSrcB));
    checkField(label, "memToReg", 3'(memToReg), 3'(expMemToReg));
    checkField(label, "byteSrc", 3'(byteSrc), 3'(expByteSrc));
endtask

// Outputs are sampled at the falling edge away from the driving edge
task automatic expectWord(input controlPkg::seqT s, input int st, input string label);
    @(posedge clk);
    @(negedge clk);
    setExpected(s, st);
    compareWord(label);
endtask

task automatic testReset(input int cycles);
    for (int i = 0; i < cycles - 1; i++) begin
        expectWord(controlPkg::seqReset, 0, "reset");
    end
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    setExpected(controlPkg::seqReset, 0);
    compareWord("reset release");
    // Reset word stays one more cycle after release
    expectWord(controlPkg::seqReset, 0, "after reset");
endtask

// Whole instruction from fetch through decode to the execute words
task automatic runInstr(input logic [5:0] op, input logic [5:0] fn, input string label);
    controlPkg::seqT s;
    int len;
    s = controlPkg::seqFetch;
    len = 0;
    if (op == controlPkg::opAddi) begin
        s = controlPkg::seqAddi;
        len = 3;
    end else if (op == controlPkg::opLb) begin
        s = controlPkg::seqLb;
        len = 4;
    end else if (op == controlPkg::opR && fn == controlPkg::fnAdd) begin
        s = controlPkg::seqAdd;
        len = 3;
    end else if (op == controlPkg::opR && fn == controlPkg::fnMfhi) begin
        s = controlPkg::seqMfhi;
        len = 2;
    end else if (op == controlPkg::opR && fn == controlPkg::fnMflo) begin
        s = controlPkg::seqMflo;
        len = 2;
    end
    @(posedge clk);
    opcode <= op;
    funct  <= fn;
    @(negedge clk);
    setExpected(controlPkg::seqFetch, 0);
    compareWord(label);
    for (int i = 1; i < 5; i++) begin
        expectWord(controlPkg::seqFetch, i, label);
    end
    expectWord(controlPkg::seqDecode, 0, label);
    for (int i = 0; i < len; i++) begin
        expectWord(s, i, label);
    end
endtask

`endif

/* dv/controlUnitTb.sv */
`timescale 1ns/100ps

module controlUnitTb;

    // Each instruction takes fetch 5 and decode 1 plus its execute steps
    localparam int randomPairs = 8;
    localparam int instrCycles = 9 + 9 + 8 + 8 + 10 + randomPairs * 10 + 9;
    localparam int resetCycles = 16;
    localparam int cycleLimit  = 2 * instrCycles + resetCycles + 4;

    logic                 clk;
    logic                 reset;
    controlPkg::opcodeT   opcode;
    controlPkg::functT    funct;
    logic                 pcWrite;
    logic                 memRead;
    logic                 irWrite;
    logic                 regWrite;
    logic                 loadA;
    logic                 loadB;
    logic                 aluOutWrite;
    logic                 mdrWrite;
    logic                 selectByte;
    logic                 cpuReset;
    controlPkg::aluOpT    aluOp;
    controlPkg::iorDT     iorD;
    controlPkg::regDstT   regDst;
    controlPkg::aluSrcAT  aluSrcA;
    controlPkg::aluSrcBT  aluSrcB;
    controlPkg::memToRegT memToReg;
    controlPkg::byteSrcT  byteSrc;

    int checkCount;
    int errorCount;
    int cycleCount;

    controlUnit controlUnit_i (
        .clk         (clk),
        .reset       (reset),
        .opcode      (opcode),
        .funct       (funct),
        .pcWrite     (pcWrite),
        .memRead     (memRead),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .loadA       (loadA),
        .loadB       (loadB),
        .aluOutWrite (aluOutWrite),
        .mdrWrite    (mdrWrite),
        .selectByte  (selectByte),
        .cpuReset    (cpuReset),
        .aluOp       (aluOp),
        .iorD        (iorD),
        .regDst      (regDst),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .memToReg    (memToReg),
        .byteSrc     (byteSrc)
    );

    `include "controlUnitTasks.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        logic [5:0] op;
        logic [5:0] fn;
        reset      = 1'b1;
        opcode     = '0;
        funct      = '0;
        checkCount = 0;
        errorCount = 0;
        cycleCount = 0;
        lfsrState  = 16'd63986;
        testReset(resetCycles);
        runInstr(controlPkg::opR, controlPkg::fnAdd, "ADD");
        runInstr(controlPkg::opAddi, 6'h15, "ADDI");
        runInstr(controlPkg::opR, controlPkg::fnMfhi, "MFHI");
        runInstr(controlPkg::opR, controlPkg::fnMflo, "MFLO");
        runInstr(controlPkg::opLb, 6'h2a, "LB");
        for (int i = 0; i < randomPairs; i++) begin
            drawPair(op, fn);
            // Half the draws stay R-type so the funct space gets covered
            if (i % 2 == 0) begin
                op = controlPkg::opR;
            end
            runInstr(op, fn, "random");
        end
        // Fetch must resume cleanly after the last random pair
        runInstr(controlPkg::opR, controlPkg::fnAdd, "ADD after random");
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* logic/controlPkg.sv */
package controlPkg;

    // Sequences the control unit can be in
    typedef enum logic [4:0] {
        seqReset,
        seqFetch,
        seqDecode,
        seqAdd,
        seqAddi,
        seqMfhi,
        seqMflo,
        seqLb
    } seqT;

    // Step count within a sequence
    typedef logic [2:0] stepT;

    // Instruction fields
    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    localparam opcodeT opR    = 6'h00;
    localparam opcodeT opAddi = 6'h08;
    localparam opcodeT opLb   = 6'h20;

    localparam functT fnAdd  = 6'h20;
    localparam functT fnMfhi = 6'h10;
    localparam functT fnMflo = 6'h12;

    // ALU operation
    typedef logic [2:0] aluOpT;
    localparam aluOpT aluAdd = 3'd1;

    // Memory address select
    typedef logic [2:0] iorDT;
    localparam iorDT iorDPc     = 3'd0;
    localparam iorDT iorDAluOut = 3'd1;

    // Register file write address select
    typedef logic [1:0] regDstT;
    localparam regDstT regDstRt = 2'd0;
    localparam regDstT regDstRd = 2'd1;

    // ALU operand selects
    typedef logic [1:0] aluSrcAT;
    localparam aluSrcAT srcAPc   = 2'd1;
    localparam aluSrcAT srcARegA = 2'd2;

    typedef logic [2:0] aluSrcBT;
    localparam aluSrcBT srcBRegB      = 3'd0;
    localparam aluSrcBT srcBFour      = 3'd1;
    localparam aluSrcBT srcBImm       = 3'd2;
    localparam aluSrcBT srcBBranchOff = 3'd4;

    // Register file write data select
    typedef logic [2:0] memToRegT;
    localparam memToRegT m2rMdr    = 3'd0;
    localparam memToRegT m2rHi     = 3'd2;
    localparam memToRegT m2rLo     = 3'd3;
    localparam memToRegT m2rAluOut = 3'd6;

    // Byte select source
    typedef logic [1:0] byteSrcT;
    localparam byteSrcT byteSrcMem = 2'd0;
    localparam byteSrcT byteSrcReg = 2'd2;

    // Number of steps in each sequence
    localparam stepT fetchLen = 3'd5;
    localparam stepT addLen   = 3'd3;
    localparam stepT moveLen  = 3'd2;
    localparam stepT lbLen    = 3'd4;

endpackage

/* logic/controlUnit.sv */
`timescale 1ns/100ps

module controlUnit (
    input  logic                  clk,
    input  logic                  reset,
    input  controlPkg::opcodeT    opcode,
    input  controlPkg::functT     funct,
    output logic                  pcWrite,
    output logic                  memRead,
    output logic                  irWrite,
    output logic                  regWrite,
    output logic                  loadA,
    output logic                  loadB,
    output logic                  aluOutWrite,
    output logic                  mdrWrite,
    output logic                  selectByte,
    output logic                  cpuReset,
    output controlPkg::aluOpT     aluOp,
    output controlPkg::iorDT      iorD,
    output controlPkg::regDstT    regDst,
    output controlPkg::aluSrcAT   aluSrcA,
    output controlPkg::aluSrcBT   aluSrcB,
    output controlPkg::memToRegT  memToReg,
    output controlPkg::byteSrcT   byteSrc
);

    controlPkg::seqT  nextSeq;
    controlPkg::seqT  seq;
    controlPkg::stepT step;

    // Sequence chosen at decode
    instrDecoder instrDecoder_i (
        .opcode  (opcode),
        .funct   (funct),
        .nextSeq (nextSeq)
    );

    stepSequencer stepSequencer_i (
        .clk     (clk),
        .reset   (reset),
        .nextSeq (nextSeq),
        .seq     (seq),
        .step    (step)
    );

    // Registered control outputs
    controlWordTable controlWordTable_i (
        .clk         (clk),
        .reset       (reset),
        .seq         (seq),
        .step        (step),
        .pcWrite     (pcWrite),
        .memRead     (memRead),
        .irWrite     (irWrite),
        .regWrite    (regWrite),
        .loadA       (loadA),
        .loadB       (loadB),
        .aluOutWrite (aluOutWrite),
        .mdrWrite    (mdrWrite),
        .selectByte  (selectByte),
        .cpuReset    (cpuReset),
        .aluOp       (aluOp),
        .iorD        (iorD),
        .regDst      (regDst),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .memToReg    (memToReg),
        .byteSrc     (byteSrc)
    );

endmodule

/* logic/controlWordTable.sv */
`timescale 1ns/100ps

module controlWordTable (
    input  logic                  clk,
    input  logic                  reset,
    input  controlPkg::seqT       seq,
    input  controlPkg::stepT      step,
    output logic                  pcWrite,
    output logic                  memRead,
    output logic                  irWrite,
    output logic                  regWrite,
    output logic                  loadA,
    output logic                  loadB,
    output logic                  aluOutWrite,
    output logic                  mdrWrite,
    output logic                  selectByte,
    output logic                  cpuReset,
    output controlPkg::aluOpT     aluOp,
    output controlPkg::iorDT      iorD,
    output controlPkg::regDstT    regDst,
    output controlPkg::aluSrcAT   aluSrcA,
    output controlPkg::aluSrcBT   aluSrcB,
    output controlPkg::memToRegT  memToReg,
    output controlPkg::byteSrcT   byteSrc
);

    logic                 pcWriteNext;
    logic                 memReadNext;
    logic                 irWriteNext;
    logic                 regWriteNext;
    logic                 loadANext;
    logic                 loadBNext;
    logic                 aluOutWriteNext;
    logic                 mdrWriteNext;
    logic                 selectByteNext;
    logic                 cpuResetNext;
    controlPkg::aluOpT    aluOpNext;
    controlPkg::iorDT     iorDNext;
    controlPkg::regDstT   regDstNext;
    controlPkg::aluSrcAT  aluSrcANext;
    controlPkg::aluSrcBT  aluSrcBNext;
    controlPkg::memToRegT memToRegNext;
    controlPkg::byteSrcT  byteSrcNext;

    // Control word for the current step
    always_comb begin
        pcWriteNext     = 1'b0;
        memReadNext     = 1'b0;
        irWriteNext     = 1'b0;
        regWriteNext    = 1'b0;
        loadANext       = 1'b0;
        loadBNext       = 1'b0;
        aluOutWriteNext = 1'b0;
        mdrWriteNext    = 1'b0;
        selectByteNext  = 1'b0;
        cpuResetNext    = 1'b0;
        aluOpNext       = '0;
        iorDNext        = controlPkg::iorDPc;
        regDstNext      = controlPkg::regDstRt;
        aluSrcANext     = '0;
        aluSrcBNext     = controlPkg::srcBRegB;
        memToRegNext    = controlPkg::m2rMdr;
        byteSrcNext     = controlPkg::byteSrcMem;
        case (seq)
            controlPkg::seqReset: begin
                cpuResetNext = 1'b1;
            end
            controlPkg::seqFetch: begin
                memReadNext = 1'b1;
                aluOpNext   = controlPkg::aluAdd;
                aluSrcANext = controlPkg::srcAPc;
                if (step == 3'd4) begin
                    // Last fetch step loads A and B while the ALU forms the branch target
                    loadANext   = 1'b1;
                    loadBNext   = 1'b1;
                    aluSrcBNext = controlPkg::srcBBranchOff;
                end else begin
                    pcWriteNext = 1'b1;
                    irWriteNext = 1'b1;
                    iorDNext    = controlPkg::iorDPc;
                    aluSrcBNext = controlPkg::srcBFour;
                end
            end
            controlPkg::seqAdd,
            controlPkg::seqAddi: begin
                regWriteNext = 1'b1;
                regDstNext   = controlPkg::regDstRd;
                aluSrcANext  = controlPkg::srcARegA;
                aluSrcBNext  = controlPkg::srcBRegB;
                if (step == 3'd0) begin
                    aluOutWriteNext = 1'b1;
                    if (seq == controlPkg::seqAddi) begin
                        regDstNext  = controlPkg::regDstRt;
                        aluSrcBNext = controlPkg::srcBImm;
                    end
                end else begin
                    memToRegNext = controlPkg::m2rAluOut;
                    byteSrcNext  = controlPkg::byteSrcReg;
                    loadANext    = (step == 3'd2);
                    loadBNext    = (step == 3'd2);
                end
            end
            controlPkg::seqMfhi: begin
                regWriteNext = 1'b1;
                memToRegNext = controlPkg::m2rHi;
                byteSrcNext  = controlPkg::byteSrcReg;
            end
            controlPkg::seqMflo: begin
                regWriteNext = 1'b1;
                memToRegNext = controlPkg::m2rLo;
                byteSrcNext  = controlPkg::byteSrcReg;
            end
            controlPkg::seqLb: begin
                aluSrcANext = controlPkg::srcARegA;
                aluSrcBNext = controlPkg::srcBImm;
                case (step)
                    3'd0: begin
                        // Address computation
                        aluOutWriteNext = 1'b1;
                        selectByteNext  = 1'b1;
                    end
                    3'd1,
                    3'd2: begin
                        memReadNext    = 1'b1;
                        iorDNext       = controlPkg::iorDAluOut;
                        selectByteNext = 1'b1;
                    end
                    default: begin
                        // Write the loaded byte back
                        regWriteNext = 1'b1;
                        mdrWriteNext = 1'b1;
                        iorDNext     = controlPkg::iorDAluOut;
                        memToRegNext = controlPkg::m2rMdr;
                        byteSrcNext  = controlPkg::byteSrcReg;
                    end
                endcase
            end
            default: begin
                // Decode step keeps every signal low
            end
        endcase
    end

    // Outputs lag the sequencer by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pcWrite     <= 1'b0;
            memRead     <= 1'b0;
            irWrite     <= 1'b0;
            regWrite    <= 1'b0;
            loadA       <= 1'b0;
            loadB       <= 1'b0;
            aluOutWrite <= 1'b0;
            mdrWrite    <= 1'b0;
            selectByte  <= 1'b0;
            cpuReset    <= 1'b1;
            aluOp       <= '0;
            iorD        <= '0;
            regDst      <= '0;
            aluSrcA     <= '0;
            aluSrcB     <= '0;
            memToReg    <= '0;
            byteSrc     <= '0;
        end else begin
            pcWrite     <= pcWriteNext;
            memRead     <= memReadNext;
            irWrite     <= irWriteNext;
            regWrite    <= regWriteNext;
            loadA       <= loadANext;
            loadB       <= loadBNext;
            aluOutWrite <= aluOutWriteNext;
            mdrWrite    <= mdrWriteNext;
            selectByte  <= selectByteNext;
            cpuReset    <= cpuResetNext;
            aluOp       <= aluOpNext;
            iorD        <= iorDNext;
            regDst      <= regDstNext;
            aluSrcA     <= aluSrcANext;
            aluSrcB     <= aluSrcBNext;
            memToReg    <= memToRegNext;
            byteSrc     <= byteSrcNext;
        end
    end

endmodule

/* logic/instrDecoder.sv */
`timescale 1ns/100ps

module instrDecoder (
    input  controlPkg::opcodeT opcode,
    input  controlPkg::functT  funct,
    output controlPkg::seqT    nextSeq
);

    always_comb begin
        // Anything unsupported falls back to fetch
        nextSeq = controlPkg::seqFetch;
        case (opcode)
            controlPkg::opR: begin
                // R-type instructions select by funct
                case (funct)
                    controlPkg::fnAdd: begin
                        nextSeq = controlPkg::seqAdd;
                    end
                    controlPkg::fnMfhi: begin
                        nextSeq = controlPkg::seqMfhi;
                    end
                    controlPkg::fnMflo: begin
                        nextSeq = controlPkg::seqMflo;
                    end
                    default: begin
                        nextSeq = controlPkg::seqFetch;
                    end
                endcase
            end
            controlPkg::opAddi: begin
                nextSeq = controlPkg::seqAddi;
            end
            controlPkg::opLb: begin
                nextSeq = controlPkg::seqLb;
            end
            default: begin
                nextSeq = controlPkg::seqFetch;
            end
        endcase
    end

endmodule

/* logic/stepSequencer.sv */
`timescale 1ns/100ps

module stepSequencer (
    input  logic                clk,
    input  logic                reset,
    input  controlPkg::seqT     nextSeq,
    output controlPkg::seqT     seq,
    output controlPkg::stepT    step
);

    controlPkg::stepT stepLast;
    logic             atLast;

    // Final step index of the current sequence
    always_comb begin
        case (seq)
            controlPkg::seqFetch: begin
                stepLast = controlPkg::fetchLen - 3'd1;
            end
            controlPkg::seqAdd,
            controlPkg::seqAddi: begin
                stepLast = controlPkg::addLen - 3'd1;
            end
            controlPkg::seqMfhi,
            controlPkg::seqMflo: begin
                stepLast = controlPkg::moveLen - 3'd1;
            end
            controlPkg::seqLb: begin
                stepLast = controlPkg::lbLen - 3'd1;
            end
            default: begin
                // Reset and decode are single steps
                stepLast = '0;
            end
        endcase
    end

    assign atLast = (step == stepLast);

    always_ff @(posedge clk) begin
        if (reset) begin
            seq  <= controlPkg::seqReset;
            step <= '0;
        end else begin
            case (seq)
                controlPkg::seqReset: begin
                    seq  <= controlPkg::seqFetch;
                    step <= '0;
                end
                controlPkg::seqFetch: begin
                    if (atLast) begin
                        seq  <= controlPkg::seqDecode;
                        step <= '0;
                    end else begin
                        step <= step + 3'd1;
                    end
                end
                controlPkg::seqDecode: begin
                    // Opcode and funct are sampled here
                    seq  <= nextSeq;
                    step <= '0;
                end
                default: begin
                    // Execute sequences return to fetch when done
                    if (atLast) begin
                        seq  <= controlPkg::seqFetch;
                        step <= '0;
                    end else begin
                        step <= step + 3'd1;
                    end
                end
            endcase
        end
    end

endmodule
